// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_control_decoder
FILELIST := control_decoder.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== control_decoder.f ====
hw/decoder_pkg.sv
hw/isr_capture.sv
hw/op_decoder.sv
hw/reg_select.sv
hw/alu_shift_ctrl.sv
hw/ctrl_output.sv
hw/control_decoder.sv
testbench/decoder_sva.sv
testbench/decoder_checker.sv
testbench/tb_control_decoder.sv

// ==== hw/alu_shift_ctrl.sv ====
`timescale 1ns/100ps

module alu_shift_ctrl import decoder_pkg::*; (
    input  phase_t             phase,
    input  addr_mode_t         f_mode,
    input  psw_t               psw,
    input  op_class_t          op_class,
    input  logic [EX_W-1:0]    ex_state,   // Picks single opcodes inside a class
    output logic [ALU_W-1:0]   alu_ctrl,
    output logic [SHIFT_W-1:0] shift_ctrl,
    output logic               shift_en,
    output logic               set_psw
);

    logic is_asr;
    logic is_rlc;
    logic is_rrc;
    logic is_lsr;
    logic is_rol;
    logic is_ror;
    logic is_adc;
    logic is_rjp;
    logic is_sub;
    logic is_sbc;
    logic pass_ph;    // Fetch phases that route bus A through the ALU
    logic pass_ops;

    assign is_asr = (ex_state == OP_ASR);
    assign is_rlc = (ex_state == OP_RLC);
    assign is_rrc = (ex_state == OP_RRC);
    assign is_lsr = (ex_state == OP_LSR);
    assign is_rol = (ex_state == OP_ROL);
    assign is_ror = (ex_state == OP_ROR);
    assign is_adc = (ex_state == OP_ADC);
    assign is_rjp = (ex_state == OP_RJP);
    assign is_sub = (ex_state == OP_SUB);
    assign is_sbc = (ex_state == OP_SBC);

    assign pass_ph = phase inside {IF0, IF1, FF0, FF2, TF0, TF1, EX1};

    assign pass_ops = op_class.mov || op_class.jmp || op_class.ret_rit ||
                      op_class.add_adc_rjp || op_class.sub_sbc || op_class.cmp ||
                      op_class.call || op_class.rjs || op_class.br;

    always_comb begin
        alu_ctrl   = '0;
        shift_ctrl = '0;
        shift_en   = 1'b0;
        set_psw    = 1'b0;
        if (phase == EX0) begin
            alu_ctrl[ALU_X] = op_class.sub_sbc || op_class.cmp;
            alu_ctrl[ALU_Y] = pass_ops;
            alu_ctrl[ALU_Z] = op_class.or_op || op_class.rb;
            alu_ctrl[ALU_U] = is_sub || op_class.cmp || ((is_adc || is_sbc) && psw.c);
            alu_ctrl[ALU_V] = pass_ops || op_class.xor_op || op_class.rb;

            shift_en          = op_class.shift;
            shift_ctrl[SFT_A] = is_asr;
            shift_ctrl[SFT_B] = is_rol;
            shift_ctrl[SFT_C] = is_lsr || is_rol || is_rlc;
            shift_ctrl[SFT_D] = is_ror;
            shift_ctrl[SFT_E] = is_rlc || is_rrc;        // Through carry
            shift_ctrl[SFT_R] = is_asr || is_ror || is_rrc;
            shift_ctrl[SFT_L] = is_asr || is_lsr || is_rol || is_rlc;

            set_psw = op_class.clr || op_class.shift || op_class.mov ||
                      (op_class.add_adc_rjp && !is_rjp) || op_class.sub_sbc ||
                      op_class.cmp || op_class.or_op || op_class.xor_op ||
                      op_class.and_op || op_class.bit_op;
        end else begin
            alu_ctrl[ALU_X] = (phase == FF0) && (f_mode == MI);   // Decrement
            alu_ctrl[ALU_Y] = pass_ph;
            alu_ctrl[ALU_U] = (phase == IF1) || (phase == TF1);   // Increment
            alu_ctrl[ALU_V] = pass_ph;
        end
    end

endmodule

// ==== hw/control_decoder.sv ====
`timescale 1ns/100ps

module control_decoder import decoder_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                isr_valid,
    input  logic [ISR_W-1:0]    isr,
    input  phase_t              phase,
    input  psw_t                psw,
    output logic                ctrl_valid,
    output logic [NUM_REGS-1:0] src_sel,
    output logic [NUM_REGS-1:0] dst_sel,
    output logic [ALU_W-1:0]    alu_ctrl,
    output logic [SHIFT_W-1:0]  shift_ctrl,
    output logic                shift_en,
    output logic                set_psw
);

    logic                cap_valid;
    phase_t              cap_phase;
    psw_t                cap_psw;
    logic [EX_W-1:0]     ex_state;
    addr_mode_t          f_mode;
    logic [REG_W-1:0]    f_reg;
    addr_mode_t          t_mode;
    logic [REG_W-1:0]    t_reg;
    op_class_t           op_class;

    // Control word before the output register
    logic [NUM_REGS-1:0] next_src_sel;
    logic [NUM_REGS-1:0] next_dst_sel;
    logic [ALU_W-1:0]    next_alu_ctrl;
    logic [SHIFT_W-1:0]  next_shift_ctrl;
    logic                next_shift_en;
    logic                next_set_psw;

    isr_capture u_capture (
        .clk       (clk),
        .rst       (rst),
        .isr_valid (isr_valid),
        .isr       (isr),
        .phase     (phase),
        .psw       (psw),
        .cap_valid (cap_valid),
        .cap_phase (cap_phase),
        .cap_psw   (cap_psw),
        .ex_state  (ex_state),
        .f_mode    (f_mode),
        .f_reg     (f_reg),
        .t_mode    (t_mode),
        .t_reg     (t_reg)
    );

    op_decoder u_op_dec (
        .ex_state (ex_state),
        .psw      (cap_psw),
        .op_class (op_class)
    );

    reg_select u_reg_sel (
        .phase    (cap_phase),
        .f_mode   (f_mode),
        .f_reg    (f_reg),
        .t_mode   (t_mode),
        .t_reg    (t_reg),
        .op_class (op_class),
        .src_sel  (next_src_sel),
        .dst_sel  (next_dst_sel)
    );

    alu_shift_ctrl u_alu_shift (
        .phase      (cap_phase),
        .f_mode     (f_mode),
        .psw        (cap_psw),
        .op_class   (op_class),
        .ex_state   (ex_state),
        .alu_ctrl   (next_alu_ctrl),
        .shift_ctrl (next_shift_ctrl),
        .shift_en   (next_shift_en),
        .set_psw    (next_set_psw)
    );

    ctrl_output u_out (
        .clk             (clk),
        .rst             (rst),
        .word_valid      (cap_valid),
        .next_src_sel    (next_src_sel),
        .next_dst_sel    (next_dst_sel),
        .next_alu_ctrl   (next_alu_ctrl),
        .next_shift_ctrl (next_shift_ctrl),
        .next_shift_en   (next_shift_en),
        .next_set_psw    (next_set_psw),
        .ctrl_valid      (ctrl_valid),
        .src_sel         (src_sel),
        .dst_sel         (dst_sel),
        .alu_ctrl        (alu_ctrl),
        .shift_ctrl      (shift_ctrl),
        .shift_en        (shift_en),
        .set_psw         (set_psw)
    );

endmodule

// ==== hw/ctrl_output.sv ====
`timescale 1ns/100ps

module ctrl_output import decoder_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                word_valid,
    input  logic [NUM_REGS-1:0] next_src_sel,
    input  logic [NUM_REGS-1:0] next_dst_sel,
    input  logic [ALU_W-1:0]    next_alu_ctrl,
    input  logic [SHIFT_W-1:0]  next_shift_ctrl,
    input  logic                next_shift_en,
    input  logic                next_set_psw,
    output logic                ctrl_valid,
    output logic [NUM_REGS-1:0] src_sel,
    output logic [NUM_REGS-1:0] dst_sel,
    output logic [ALU_W-1:0]    alu_ctrl,
    output logic [SHIFT_W-1:0]  shift_ctrl,
    output logic                shift_en,
    output logic                set_psw
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            src_sel    <= '0;
            dst_sel    <= '0;
            alu_ctrl   <= '0;
            shift_ctrl <= '0;
            shift_en   <= 1'b0;
            set_psw    <= 1'b0;
        end else begin
            ctrl_valid <= word_valid;
            if (word_valid) begin   // Word holds between strobes
                src_sel    <= next_src_sel;
                dst_sel    <= next_dst_sel;
                alu_ctrl   <= next_alu_ctrl;
                shift_ctrl <= next_shift_ctrl;
                shift_en   <= next_shift_en;
                set_psw    <= next_set_psw;
            end
        end
    end

endmodule

// ==== hw/decoder_pkg.sv ====
package decoder_pkg;

    localparam int ISR_W    = 16;
    localparam int EX_W     = 6;
    localparam int MODE_W   = 2;
    localparam int REG_W    = 3;
    localparam int NUM_REGS = 8;
    localparam int ALU_W    = 5;
    localparam int SHIFT_W  = 7;

    // Field positions inside the ISR
    localparam int EX_LSB     = 10;
    localparam int F_MODE_LSB = 8;
    localparam int F_REG_LSB  = 5;
    localparam int T_MODE_LSB = 3;
    localparam int T_REG_LSB  = 0;

    localparam logic [REG_W-1:0] REG_SP = 3'd6;   // R6, stack pointer
    localparam logic [REG_W-1:0] REG_PC = 3'd7;   // R7, program counter

    // Bit positions in alu_ctrl and shift_ctrl
    localparam int ALU_X = 4;
    localparam int ALU_Y = 3;
    localparam int ALU_Z = 2;
    localparam int ALU_U = 1;
    localparam int ALU_V = 0;

    localparam int SFT_A = 6;
    localparam int SFT_B = 5;
    localparam int SFT_C = 4;
    localparam int SFT_D = 3;
    localparam int SFT_E = 2;
    localparam int SFT_R = 1;
    localparam int SFT_L = 0;

    typedef enum logic [MODE_W-1:0] {
        D  = 2'd0,   // Register direct
        I  = 2'd1,   // Indirect
        MI = 2'd2,   // Pre-decrement indirect
        IP = 2'd3    // Post-increment indirect
    } addr_mode_t;

    typedef enum logic [3:0] {
        IF0 = 4'd0,
        IF1 = 4'd1,
        FF0 = 4'd2,
        FF1 = 4'd3,
        FF2 = 4'd4,
        TF0 = 4'd5,
        TF1 = 4'd6,
        EX0 = 4'd7,
        EX1 = 4'd8
    } phase_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } psw_t;

    localparam logic [EX_W-1:0] OP_HLT = 6'b000000;
    localparam logic [EX_W-1:0] OP_CLR = 6'b000100;
    localparam logic [EX_W-1:0] OP_ASL = 6'b001000;
    localparam logic [EX_W-1:0] OP_ASR = 6'b001001;
    localparam logic [EX_W-1:0] OP_RLC = 6'b001010;
    localparam logic [EX_W-1:0] OP_RRC = 6'b001011;
    localparam logic [EX_W-1:0] OP_LSL = 6'b001100;
    localparam logic [EX_W-1:0] OP_LSR = 6'b001101;
    localparam logic [EX_W-1:0] OP_ROL = 6'b001110;
    localparam logic [EX_W-1:0] OP_ROR = 6'b001111;
    localparam logic [EX_W-1:0] OP_MOV = 6'b010000;
    localparam logic [EX_W-1:0] OP_JMP = 6'b010001;
    localparam logic [EX_W-1:0] OP_RET = 6'b010010;
    localparam logic [EX_W-1:0] OP_RIT = 6'b010011;
    localparam logic [EX_W-1:0] OP_ADD = 6'b010100;
    localparam logic [EX_W-1:0] OP_RJP = 6'b010101;
    localparam logic [EX_W-1:0] OP_ADC = 6'b010110;
    localparam logic [EX_W-1:0] OP_SUB = 6'b011000;
    localparam logic [EX_W-1:0] OP_SBC = 6'b011010;
    localparam logic [EX_W-1:0] OP_CMP = 6'b011011;
    localparam logic [EX_W-1:0] OP_OR  = 6'b100000;
    localparam logic [EX_W-1:0] OP_XOR = 6'b100001;
    localparam logic [EX_W-1:0] OP_AND = 6'b100010;
    localparam logic [EX_W-1:0] OP_BIT = 6'b100011;
    localparam logic [EX_W-1:0] OP_JSR = 6'b101100;
    localparam logic [EX_W-1:0] OP_RJS = 6'b101101;
    localparam logic [EX_W-1:0] OP_SVC = 6'b101110;
    localparam logic [EX_W-1:0] OP_BRN = 6'b110000;
    localparam logic [EX_W-1:0] OP_BRZ = 6'b110001;
    localparam logic [EX_W-1:0] OP_BRV = 6'b110010;
    localparam logic [EX_W-1:0] OP_BRC = 6'b110011;
    localparam logic [EX_W-1:0] OP_RBN = 6'b111000;
    localparam logic [EX_W-1:0] OP_RBZ = 6'b111001;
    localparam logic [EX_W-1:0] OP_RBV = 6'b111010;
    localparam logic [EX_W-1:0] OP_RBC = 6'b111011;

    typedef struct packed {
        logic shift;
        logic clr;
        logic mov;
        logic jmp;
        logic ret_rit;
        logic add_adc_rjp;
        logic sub_sbc;
        logic cmp;
        logic or_op;
        logic xor_op;
        logic and_op;
        logic bit_op;
        logic call;          // JSR or SVC
        logic rjs;
        logic br;
        logic rb;
        logic branch_taken;
    } op_class_t;

endpackage

// ==== hw/isr_capture.sv ====
`timescale 1ns/100ps

module isr_capture import decoder_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             isr_valid,
    input  logic [ISR_W-1:0] isr,
    input  phase_t           phase,
    input  psw_t             psw,
    output logic             cap_valid,
    output phase_t           cap_phase,
    output psw_t             cap_psw,
    output logic [EX_W-1:0]  ex_state,
    output addr_mode_t       f_mode,
    output logic [REG_W-1:0] f_reg,
    output addr_mode_t       t_mode,
    output logic [REG_W-1:0] t_reg
);

    logic [ISR_W-1:0] isr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= isr_valid;
        end
    end

    // Held until the next strobe
    always_ff @(posedge clk) begin
        if (isr_valid) begin
            isr_q     <= isr;
            cap_phase <= phase;
            cap_psw   <= psw;
        end
    end

    assign ex_state = isr_q[EX_LSB +: EX_W];
    assign f_mode   = addr_mode_t'(isr_q[F_MODE_LSB +: MODE_W]);   // Source operand
    assign f_reg    = isr_q[F_REG_LSB +: REG_W];
    assign t_mode   = addr_mode_t'(isr_q[T_MODE_LSB +: MODE_W]);   // Destination operand
    assign t_reg    = isr_q[T_REG_LSB +: REG_W];

endmodule

// ==== hw/op_decoder.sv ====
`timescale 1ns/100ps

module op_decoder import decoder_pkg::*; (
    input  logic [EX_W-1:0] ex_state,
    input  psw_t            psw,
    output op_class_t       op_class
);

    logic tested_flag;

    // Low two opcode bits pick the flag of a conditional branch
    always_comb begin
        case (ex_state[1:0])
            2'd0:    tested_flag = psw.n;
            2'd1:    tested_flag = psw.z;
            2'd2:    tested_flag = psw.v;
            default: tested_flag = psw.c;
        endcase
    end

    // HLT and the NOP range fall through with every flag low
    always_comb begin
        op_class = '0;

        op_class.shift = (ex_state == OP_ASL) || (ex_state == OP_ASR) ||
                         (ex_state == OP_RLC) || (ex_state == OP_RRC) ||
                         (ex_state == OP_LSL) || (ex_state == OP_LSR) ||
                         (ex_state == OP_ROL) || (ex_state == OP_ROR);

        op_class.clr     = (ex_state == OP_CLR);
        op_class.mov     = (ex_state == OP_MOV);
        op_class.jmp     = (ex_state == OP_JMP);
        op_class.ret_rit = (ex_state == OP_RET) || (ex_state == OP_RIT);

        op_class.add_adc_rjp = (ex_state == OP_ADD) || (ex_state == OP_ADC) ||
                               (ex_state == OP_RJP);
        op_class.sub_sbc     = (ex_state == OP_SUB) || (ex_state == OP_SBC);
        op_class.cmp         = (ex_state == OP_CMP);

        op_class.or_op  = (ex_state == OP_OR);
        op_class.xor_op = (ex_state == OP_XOR);
        op_class.and_op = (ex_state == OP_AND);
        op_class.bit_op = (ex_state == OP_BIT);

        op_class.call = (ex_state == OP_JSR) || (ex_state == OP_SVC);
        op_class.rjs  = (ex_state == OP_RJS);

        op_class.br = (ex_state == OP_BRN) || (ex_state == OP_BRZ) ||
                      (ex_state == OP_BRV) || (ex_state == OP_BRC);
        op_class.rb = (ex_state == OP_RBN) || (ex_state == OP_RBZ) ||
                      (ex_state == OP_RBV) || (ex_state == OP_RBC);

        op_class.branch_taken = (op_class.br || op_class.rb) && tested_flag;
    end

endmodule

// ==== hw/reg_select.sv ====
`timescale 1ns/100ps

module reg_select import decoder_pkg::*; (
    input  phase_t              phase,
    input  addr_mode_t          f_mode,
    input  logic [REG_W-1:0]    f_reg,
    input  addr_mode_t          t_mode,
    input  logic [REG_W-1:0]    t_reg,
    input  op_class_t           op_class,
    output logic [NUM_REGS-1:0] src_sel,
    output logic [NUM_REGS-1:0] dst_sel
);

    function automatic logic [NUM_REGS-1:0] onehot(input logic [REG_W-1:0] num);
        onehot = NUM_REGS'(1) << num;
    endfunction

    logic writes_t;   // Result goes back to a direct destination register

    assign writes_t = (t_mode == D) &&
                      (op_class.shift  || op_class.clr    || op_class.mov ||
                       op_class.add_adc_rjp || op_class.or_op ||
                       op_class.xor_op || op_class.and_op);

    // Bus A read select
    always_comb begin
        src_sel = '0;
        case (phase)
            IF0, IF1: src_sel = onehot(REG_PC);
            FF0:      src_sel = onehot(f_reg);
            FF1: begin
                if (f_mode == IP) src_sel = onehot(f_reg);   // Address bump
            end
            TF0:      src_sel = onehot(t_reg);
            TF1: begin
                if (t_mode == IP) src_sel = onehot(t_reg);
            end
            EX0: begin
                if (op_class.ret_rit) src_sel = onehot(REG_SP);
            end
            EX1: begin
                if (op_class.rjs) src_sel = onehot(REG_PC);
            end
            default: src_sel = '0;
        endcase
    end

    // Store select
    always_comb begin
        dst_sel = '0;
        case (phase)
            IF1: dst_sel = onehot(REG_PC);   // PC increment
            FF0: dst_sel = onehot(f_reg);
            FF1: begin
                if (f_mode == IP) dst_sel = onehot(f_reg);
            end
            TF1: begin
                if (t_mode == IP) dst_sel = onehot(t_reg);
            end
            EX0: begin
                if (writes_t) begin
                    dst_sel = onehot(t_reg);
                end else if (op_class.jmp || op_class.ret_rit || op_class.branch_taken) begin
                    dst_sel = onehot(REG_PC);
                end
            end
            EX1: begin
                if (op_class.call || op_class.rjs) dst_sel = onehot(REG_PC);
            end
            default: dst_sel = '0;
        endcase
    end

endmodule

// ==== testbench/decoder_checker.sv ====
`timescale 1ns/100ps

module decoder_checker import decoder_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                exp_push,
    input  logic [NUM_REGS-1:0] exp_src_sel,
    input  logic [NUM_REGS-1:0] exp_dst_sel,
    input  logic [ALU_W-1:0]    exp_alu_ctrl,
    input  logic [SHIFT_W-1:0]  exp_shift_ctrl,
    input  logic                exp_shift_en,
    input  logic                exp_set_psw,
    input  logic                ctrl_valid,
    input  logic [NUM_REGS-1:0] src_sel,
    input  logic [NUM_REGS-1:0] dst_sel,
    input  logic [ALU_W-1:0]    alu_ctrl,
    input  logic [SHIFT_W-1:0]  shift_ctrl,
    input  logic                shift_en,
    input  logic                set_psw,
    input  logic                end_check,
    output int                  pending,
    output int                  field_errors,
    output int                  protocol_errors
);

    typedef struct packed {
        logic [NUM_REGS-1:0] src_sel;
        logic [NUM_REGS-1:0] dst_sel;
        logic [ALU_W-1:0]    alu_ctrl;
        logic [SHIFT_W-1:0]  shift_ctrl;
        logic                shift_en;
        logic                set_psw;
    } word_t;

    word_t expected_q[$];
    word_t exp_word;
    word_t push_word;

    task automatic check_field(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("Error: %s expected 0x%0h, actual 0x%0h at %0t", name, exp, act, $time);
            field_errors++;
        end
    endtask

    // Sampled on the falling edge, away from the DUT's register updates
    always @(negedge clk) begin
        if (rst) begin
            expected_q.delete();
            field_errors    = 0;
            protocol_errors = 0;
        end else begin
            if (ctrl_valid) begin
                if (expected_q.size() == 0) begin
                    $display("A control word came out at %0t while none was expected", $time);
                    protocol_errors++;
                end else begin
                    exp_word = expected_q.pop_front();
                    check_field("src_sel", exp_word.src_sel, src_sel);
                    check_field("dst_sel", exp_word.dst_sel, dst_sel);
                    check_field("alu_ctrl", 8'(exp_word.alu_ctrl), 8'(alu_ctrl));
                    check_field("shift_ctrl", 8'(exp_word.shift_ctrl), 8'(shift_ctrl));
                    check_field("shift_en", 8'(exp_word.shift_en), 8'(shift_en));
                    check_field("set_psw", 8'(exp_word.set_psw), 8'(set_psw));
                end
            end
            if (exp_push) begin
                push_word.src_sel    = exp_src_sel;
                push_word.dst_sel    = exp_dst_sel;
                push_word.alu_ctrl   = exp_alu_ctrl;
                push_word.shift_ctrl = exp_shift_ctrl;
                push_word.shift_en   = exp_shift_en;
                push_word.set_psw    = exp_set_psw;
                expected_q.push_back(push_word);
            end
            if (end_check && expected_q.size() != 0) begin
                $display("%0d expected control words were never produced", expected_q.size());
                protocol_errors++;
                expected_q.delete();
            end
        end
        pending = expected_q.size();
    end

endmodule

// ==== testbench/decoder_golden.txt ====
# Columns in hex: isr phase psw | expected src_sel dst_sel alu_ctrl shift_ctrl shift_en set_psw
# Phase codes IF0=0 IF1=1 FF0=2 FF1=3 FF2=4 TF0=5 TF1=6 EX0=7 EX1=8, psw bits n z v c
0000 0 0 80 00 09 00 0 0
0000 1 f 80 80 0b 00 0 0
0060 2 0 08 08 09 00 0 0
02a0 2 0 20 20 19 00 0 0
0100 2 0 01 01 09 00 0 0
0340 3 0 04 04 00 00 0 0
0080 3 0 00 00 00 00 0 0
03e0 4 0 00 00 09 00 0 0
0009 5 0 02 00 09 00 0 0
001e 6 0 40 40 0b 00 0 0
0015 6 0 00 00 0b 00 0 0
0007 5 0 80 00 09 00 0 0
2003 7 0 00 08 00 00 1 1
2401 7 0 00 02 00 43 1 1
280a 7 0 00 00 00 15 1 1
2c00 7 0 00 01 00 06 1 1
301c 7 0 00 00 00 00 1 1
3405 7 0 00 20 00 11 1 1
3806 7 0 00 40 00 31 1 1
3c07 7 0 00 80 00 0a 1 1
5002 7 1 00 04 09 00 0 1
5402 7 0 00 04 09 00 0 0
5802 7 0 00 04 09 00 0 1
5802 7 1 00 04 0b 00 0 1
6002 7 0 00 00 1b 00 0 1
6802 7 0 00 00 19 00 0 1
6802 7 1 00 00 1b 00 0 1
6c02 7 0 00 00 1b 00 0 1
8002 7 0 00 04 04 00 0 1
8402 7 0 00 04 01 00 0 1
8802 7 0 00 04 00 00 0 1
8c02 7 0 00 00 00 00 0 1
400a 7 0 00 00 09 00 0 1
1005 7 0 00 20 00 00 0 1
4400 7 0 00 80 09 00 0 0
4800 7 0 40 80 09 00 0 0
4c00 7 0 40 80 09 00 0 0
c000 7 8 00 80 09 00 0 0
c400 7 b 00 00 09 00 0 0
c800 7 2 00 80 09 00 0 0
cc00 7 e 00 00 09 00 0 0
e000 7 7 00 00 05 00 0 0
e400 7 4 00 80 05 00 0 0
e800 7 d 00 00 05 00 0 0
ec00 7 1 00 80 05 00 0 0
b000 8 0 00 80 09 00 0 0
b800 8 0 00 80 09 00 0 0
b400 8 0 80 80 09 00 0 0
b000 7 0 00 00 09 00 0 0
0000 7 f 00 00 00 00 0 0
2003 8 0 00 00 09 00 0 0

// ==== testbench/decoder_sva.sv ====
`timescale 1ns/100ps

module decoder_sva import decoder_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                isr_valid,
    input logic                ctrl_valid,
    input logic [NUM_REGS-1:0] src_sel,
    input logic [NUM_REGS-1:0] dst_sel
);

    int failures = 0;

    // Fixed two-cycle latency from strobe to control word
    a_valid_after_strobe: assert property (@(posedge clk) disable iff (rst)
        $past(isr_valid, 2) |-> ctrl_valid)
        else begin
            $error("ctrl_valid missing two cycles after an isr_valid strobe");
            failures++;
        end

    a_no_extra_valid: assert property (@(posedge clk) disable iff (rst)
        ctrl_valid |-> $past(isr_valid, 2))
        else begin
            $error("ctrl_valid raised without an isr_valid strobe two cycles before");
            failures++;
        end

    a_src_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(src_sel))
        else begin
            $error("src_sel has more than one register selected");
            failures++;
        end

    a_dst_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dst_sel))
        else begin
            $error("dst_sel has more than one register selected");
            failures++;
        end

endmodule

bind control_decoder decoder_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .isr_valid  (isr_valid),
    .ctrl_valid (ctrl_valid),
    .src_sel    (src_sel),
    .dst_sel    (dst_sel)
);

// ==== testbench/tb_control_decoder.sv ====
`timescale 1ns/100ps

module tb_control_decoder import decoder_pkg::*; ();

    localparam string GOLDEN_FILE  = "testbench/decoder_golden.txt";
    localparam int    RESET_CYCLES = 16;

    typedef struct packed {
        logic [ISR_W-1:0]    isr;
        logic [3:0]          phase;
        logic [3:0]          psw;
        logic [NUM_REGS-1:0] src_sel;
        logic [NUM_REGS-1:0] dst_sel;
        logic [ALU_W-1:0]    alu_ctrl;
        logic [SHIFT_W-1:0]  shift_ctrl;
        logic                shift_en;
        logic                set_psw;
    } vector_t;

    logic                clk;
    logic                rst;
    logic                isr_valid;
    logic [ISR_W-1:0]    isr;
    phase_t              phase;
    psw_t                psw;
    logic                ctrl_valid;
    logic [NUM_REGS-1:0] src_sel;
    logic [NUM_REGS-1:0] dst_sel;
    logic [ALU_W-1:0]    alu_ctrl;
    logic [SHIFT_W-1:0]  shift_ctrl;
    logic                shift_en;
    logic                set_psw;

    logic                exp_push;   // Expected word goes with each strobe
    vector_t             exp_vec;
    logic                end_check;
    int                  pending;
    int                  field_errors;
    int                  protocol_errors;

    vector_t vectors[$];
    int      cycle_count = 0;
    int      cycle_limit = 0;

    control_decoder u_dut (
        .clk        (clk),
        .rst        (rst),
        .isr_valid  (isr_valid),
        .isr        (isr),
        .phase      (phase),
        .psw        (psw),
        .ctrl_valid (ctrl_valid),
        .src_sel    (src_sel),
        .dst_sel    (dst_sel),
        .alu_ctrl   (alu_ctrl),
        .shift_ctrl (shift_ctrl),
        .shift_en   (shift_en),
        .set_psw    (set_psw)
    );

    decoder_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .exp_push        (exp_push),
        .exp_src_sel     (exp_vec.src_sel),
        .exp_dst_sel     (exp_vec.dst_sel),
        .exp_alu_ctrl    (exp_vec.alu_ctrl),
        .exp_shift_ctrl  (exp_vec.shift_ctrl),
        .exp_shift_en    (exp_vec.shift_en),
        .exp_set_psw     (exp_vec.set_psw),
        .ctrl_valid      (ctrl_valid),
        .src_sel         (src_sel),
        .dst_sel         (dst_sel),
        .alu_ctrl        (alu_ctrl),
        .shift_ctrl      (shift_ctrl),
        .shift_en        (shift_en),
        .set_psw         (set_psw),
        .end_check       (end_check),
        .pending         (pending),
        .field_errors    (field_errors),
        .protocol_errors (protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic read_golden(output bit ok);
        int          fd;
        int          count;
        string       line;
        logic [31:0] c_isr;
        logic [31:0] c_phase;
        logic [31:0] c_psw;
        logic [31:0] c_src;
        logic [31:0] c_dst;
        logic [31:0] c_alu;
        logic [31:0] c_shift;
        logic [31:0] c_en;
        logic [31:0] c_set;
        vector_t     v;
        ok = 1'b1;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin   // Skip blanks and column notes
                    count = $sscanf(line, "%h %h %h %h %h %h %h %h %h", c_isr, c_phase, c_psw,
                                    c_src, c_dst, c_alu, c_shift, c_en, c_set);
                    if (count == 9) begin
                        v.isr        = c_isr[ISR_W-1:0];
                        v.phase      = c_phase[3:0];
                        v.psw        = c_psw[3:0];
                        v.src_sel    = c_src[NUM_REGS-1:0];
                        v.dst_sel    = c_dst[NUM_REGS-1:0];
                        v.alu_ctrl   = c_alu[ALU_W-1:0];
                        v.shift_ctrl = c_shift[SHIFT_W-1:0];
                        v.shift_en   = c_en[0];
                        v.set_psw    = c_set[0];
                        vectors.push_back(v);
                    end else begin
                        $display("Golden file line could not be parsed: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0) ok = 1'b0;
    endtask

    task automatic apply_vector(input vector_t v);
        isr_valid = 1'b1;
        isr       = v.isr;
        phase     = phase_t'(v.phase);
        psw       = v.psw;
        exp_push  = 1'b1;
        exp_vec   = v;
    endtask

    // Junk on the data inputs while the strobe is low
    task automatic idle_inputs();
        isr_valid = 1'b0;
        isr       = '1;
        phase     = IF0;
        psw       = '1;
        exp_push  = 1'b0;
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        $display("Run stopped after %0d cycles with %0d control words still missing",
                 cycle_count, pending);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        bit ok;
        rst       = 1'b1;
        end_check = 1'b0;
        exp_vec   = '0;
        idle_inputs();
        read_golden(ok);
        if (!ok) begin
            $display("Golden file %s could not be read", GOLDEN_FILE);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            cycle_limit = vectors.size() * 3 + 40;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst = 1'b0;
            repeat (3) @(posedge clk);   // ctrl_valid must stay low here
            #1;
            for (int i = 0; i < vectors.size(); i++) begin
                apply_vector(vectors[i]);
                @(posedge clk);
                #1;
                if (i % 6 == 5) begin   // Idle gap of one to three cycles
                    idle_inputs();
                    repeat ((i / 6) % 3 + 1) @(posedge clk);
                    #1;
                end
            end
            idle_inputs();
            repeat (4) @(posedge clk);   // Two-cycle latency drains every word
            #1;
            end_check = 1'b1;
            @(posedge clk);
            #1;
            $display("Checks done: %0d vectors, %0d field, %0d protocol and %0d assertion errors",
                     vectors.size(), field_errors, protocol_errors, u_dut.u_sva.failures);
            if (field_errors == 0 && protocol_errors == 0 && u_dut.u_sva.failures == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule
